// File: src.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/rob_pkg.sv
rtl/inst_decode.sv
rtl/alu_unit.sv
rtl/muldiv_unit.sv
rtl/reorder_buffer.sv
rtl/ooo_core_top.sv
testbench/tb_ooo_core.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary -Wno-fatal -f src.f --top-module tb_ooo_core -o tb_ooo_core \
    && ./obj_dir/tb_ooo_core > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
! grep -q "Errors found" sim.log && grep -q "No errors" sim.log

// File: testbench/tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_cfg.svh"

module tb_ooo_core;
    import isa_pkg::*;

    // One retired instruction as the model sees it
    typedef struct packed {
        word_t    value;
        reg_idx_t dest;
        logic     reg_write;
        logic     is_div;                       // Holds issue off until it retires
    } exp_t;

    localparam int ISSUE_TIMEOUT = 200;         // Enough cycles for a full divide
    localparam int DRAIN_TIMEOUT = 4000;

    logic     clk;
    logic     rst;
    logic     flush;
    word_t    inst;
    logic     inst_valid;
    word_t    op_a;
    word_t    op_b;
    logic     issue_ready;
    logic     commit_valid;
    word_t    commit_value;
    reg_idx_t commit_dest;
    logic     commit_reg_write;

    integer seed;
    exp_t   drv_exp;                            // Expected result of the driven instruction
    exp_t   exp_q[$];                           // Program order with the oldest at the front
    string  test_name;
    int     cyc             = 0;
    int     checks          = 0;
    int     check_errors    = 0;
    int     flow_errors     = 0;
    int     stall_cycles    = 0;                // Strobe held while issue_ready low
    int     first_issue_cyc = -1;
    logic   latency_done    = 1'b0;
    logic   div_pending     = 1'b0;             // DIVU accepted and not yet retired
    int     stall_mark;

    ooo_core_top dut (
        .clk, .rst, .flush, .inst, .inst_valid, .op_a, .op_b,
        .issue_ready, .commit_valid, .commit_value, .commit_dest, .commit_reg_write
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_word(input string what, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            $display("Mismatch %s %s: expected %08h, actual %08h", test_name, what, exp, act);
            check_errors++;
        end
    endtask

    task automatic check_reg(input string what, input reg_idx_t exp, input reg_idx_t act);
        checks++;
        if (exp !== act) begin
            $display("Mismatch %s %s: expected x%0d, actual x%0d", test_name, what, exp, act);
            check_errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            $display("Mismatch %s %s: expected %0b, actual %0b", test_name, what, exp, act);
            check_errors++;
        end
    endtask

    function automatic word_t rand_word();
        rand_word = $random(seed);
    endfunction

    // Architectural result of each operation
    function automatic word_t expected_result(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            OP_ADD:  expected_result = a + b;
            OP_SUB:  expected_result = a - b;
            OP_AND:  expected_result = a & b;
            OP_OR:   expected_result = a | b;
            OP_XOR:  expected_result = a ^ b;
            OP_SLL:  expected_result = a << b[4:0];
            OP_MUL:  expected_result = a * b;       // Low half of the product
            OP_DIVU: expected_result = (b == '0) ? '1 : a / b;
            default: expected_result = '0;          // Illegal retires zero
        endcase
    endfunction

    // RV32 R-type encoding with rs1, rs2 and the illegal variant taken from r
    function automatic word_t encode_inst(input alu_op_t op, input reg_idx_t rd, input word_t r);
        logic [6:0] f7;
        logic [2:0] f3;
        logic [6:0] opc;
        opc = 7'b0110011;
        f7  = 7'b0000000;
        f3  = 3'b000;
        case (op)
            OP_SUB:  f7 = 7'b0100000;
            OP_AND:  f3 = 3'b111;
            OP_OR:   f3 = 3'b110;
            OP_XOR:  f3 = 3'b100;
            OP_SLL:  f3 = 3'b001;
            OP_MUL:  f7 = 7'b0000001;
            OP_DIVU: begin
                f7 = 7'b0000001;
                f3 = 3'b101;
            end
            OP_ILLEGAL: begin
                case (r[31:30])
                    2'd0: opc = 7'b0010011;         // OP-IMM
                    2'd1: begin                     // funct7 0100000 with AND slot
                        f7 = 7'b0100000;
                        f3 = 3'b111;
                    end
                    2'd2: begin                     // Signed DIV is not supported
                        f7 = 7'b0000001;
                        f3 = 3'b100;
                    end
                    default: opc = 7'b1100011;      // Branch
                endcase
            end
            default: f3 = 3'b000;                   // ADD
        endcase
        encode_inst = {f7, r[24:20], r[19:15], f3, rd, opc};
    endfunction

    // base/span pick a slice of ADD..SLL, MUL, DIVU, ILLEGAL
    function automatic alu_op_t pick_op(input word_t r, input int base, input int span);
        int k;
        k = base + int'(r % span);
        case (k)
            0:       pick_op = OP_ADD;
            1:       pick_op = OP_SUB;
            2:       pick_op = OP_AND;
            3:       pick_op = OP_OR;
            4:       pick_op = OP_XOR;
            5:       pick_op = OP_SLL;
            6:       pick_op = OP_MUL;
            7:       pick_op = OP_DIVU;
            default: pick_op = OP_ILLEGAL;
        endcase
    endfunction

    // Drive at the edge and hold until issue_ready is seen high
    task automatic issue_op(input alu_op_t op, input reg_idx_t rd, input word_t a,
                            input word_t b, input word_t r);
        exp_t e;
        int   n;
        e.value     = expected_result(op, a, b);
        e.dest      = rd;
        e.reg_write = (op != OP_ILLEGAL) && (rd != 5'd0);
        e.is_div    = (op == OP_DIVU);
        @(posedge clk);
        inst       <= encode_inst(op, rd, r);
        op_a       <= a;
        op_b       <= b;
        inst_valid <= 1'b1;
        drv_exp    <= e;
        n = 0;
        @(negedge clk);
        while (!issue_ready && n < ISSUE_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!issue_ready) begin
            $display("Timeout in %s: issue_ready stayed low, instruction was not issued",
                     test_name);
            flow_errors++;
        end
    endtask

    task automatic issue_random(input int base, input int span);
        alu_op_t op;
        word_t   a;
        word_t   b;
        word_t   r;
        op = pick_op(rand_word(), base, span);
        a  = rand_word();
        b  = rand_word();
        r  = rand_word();
        if (op == OP_DIVU) begin
            if (r[7:6] == 2'b00) begin
                b = '0;                             // Quarter of divides by zero
            end else begin
                b = b >> r[12:8];                   // Spread the quotient sizes
            end
        end
        issue_op(op, r[4:0], a, b, r);
    endtask

    task automatic idle_cycles(input int n);
        @(posedge clk);
        inst_valid <= 1'b0;
        repeat (n - 1) @(posedge clk);
    endtask

    task automatic pulse_flush(input logic with_strobe);
        @(posedge clk);
        flush      <= 1'b1;
        inst_valid <= with_strobe;                  // Must be dropped
        inst       <= encode_inst(OP_ADD, 5'd7, rand_word());
        @(posedge clk);
        flush      <= 1'b0;
        inst_valid <= 1'b0;
    endtask

    task automatic drain();
        int n;
        @(posedge clk);
        inst_valid <= 1'b0;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout in %s: %0d commits never arrived", test_name, exp_q.size());
            flow_errors++;
        end
        repeat (3) @(posedge clk);                  // Room for a stray commit to show
    endtask

    // Model where commits pop, accepted strobes push and flush empties the queue
    always @(negedge clk) begin : monitor
        exp_t e;
        if (rst) begin
            exp_q.delete();
            div_pending = 1'b0;
        end else begin
            if (commit_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected commit in %s: x%0d = %08h with nothing outstanding",
                             test_name, commit_dest, commit_value);
                    check_errors++;
                end else begin
                    e = exp_q.pop_front();
                    if (e.is_div) div_pending = 1'b0;   // Divider frees as the quotient retires
                    check_word("value", e.value, commit_value);
                    check_reg("dest", e.dest, commit_dest);
                    check_bit("reg_write", e.reg_write, commit_reg_write);
                    if (!latency_done && first_issue_cyc >= 0) begin
                        latency_done = 1'b1;        // Only the first one after reset
                        checks++;
                        if (cyc - first_issue_cyc != 2) begin
                            $display("Mismatch %s latency: expected 2, actual %0d",
                                     test_name, cyc - first_issue_cyc);
                            check_errors++;
                        end
                    end
                end
            end
            // Queue depth equals ROB occupancy once this cycle's commit is popped
            check_bit("issue_ready", !div_pending && (exp_q.size() < `ROB_DEPTH), issue_ready);
            if (flush) begin
                exp_q.delete();                     // Everything in flight is gone
                div_pending = 1'b0;
            end else if (inst_valid && issue_ready) begin
                exp_q.push_back(drv_exp);
                if (drv_exp.is_div) div_pending = 1'b1;
                if (first_issue_cyc < 0) first_issue_cyc = cyc;
            end
            if (inst_valid && !issue_ready) stall_cycles++;
        end
    end

    initial begin
        seed       = 40853;
        rst        = 1'b1;
        flush      = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        op_a       = '0;
        op_b       = '0;
        drv_exp    = '0;
        test_name  = "reset";
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        test_name = "alu_first";
        issue_op(OP_ADD, 5'd5, rand_word(), rand_word(), rand_word());
        drain();

        test_name = "alu_random";
        for (int i = 0; i < 40; i++) issue_random(0, 6);
        drain();

        test_name = "muldiv";
        issue_op(OP_DIVU, 5'd9, rand_word(), '0, rand_word());
        issue_op(OP_MUL, 5'd10, 32'hffff_ffff, 32'hffff_ffff, rand_word());
        for (int i = 0; i < 30; i++) issue_random(6, 2);
        drain();

        test_name = "mixed";
        for (int i = 0; i < 4; i++) begin
            issue_random(7, 1);                     // DIVU ahead of fast ops
            issue_random(0, 6);
            issue_random(6, 1);
            issue_random(0, 6);
        end
        for (int i = 0; i < 40; i++) issue_random(0, 9);
        drain();

        test_name  = "fill";
        stall_mark = stall_cycles;
        issue_random(7, 1);
        for (int i = 0; i < 60; i++) issue_random(0, 9);
        drain();
        if (stall_cycles == stall_mark) begin
            $display("Back-to-back issue in %s never saw issue_ready low", test_name);
            flow_errors++;
        end

        test_name = "flush";
        issue_random(6, 1);
        issue_random(0, 6);
        issue_random(6, 1);
        issue_random(6, 1);
        pulse_flush(1'b1);                          // MULs in the pipe and a strobe alongside
        idle_cycles(12);
        issue_random(7, 1);
        idle_cycles(8);
        pulse_flush(1'b0);                          // Mid-divide
        idle_cycles(45);
        for (int i = 0; i < 20; i++) issue_random(0, 9);
        drain();

        test_name = "rd0_illegal";
        issue_op(OP_ADD, 5'd0, rand_word(), rand_word(), rand_word());
        issue_op(OP_MUL, 5'd0, rand_word(), rand_word(), rand_word());
        for (int i = 0; i < 8; i++) begin
            issue_op(OP_ILLEGAL, reg_idx_t'(i + 1), rand_word(), rand_word(), rand_word());
        end
        issue_op(OP_ILLEGAL, 5'd0, rand_word(), rand_word(), rand_word());
        issue_op(OP_SUB, 5'd0, rand_word(), rand_word(), rand_word());
        drain();

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checks, check_errors, flow_errors);
        if (check_errors == 0 && flow_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/ooo_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           flush,
    input  wire isa_pkg::word_t inst,
    input  wire logic           inst_valid,
    input  wire isa_pkg::word_t op_a,
    input  wire isa_pkg::word_t op_b,
    output logic                issue_ready,
    output logic                commit_valid,
    output isa_pkg::word_t      commit_value,
    output isa_pkg::reg_idx_t   commit_dest,
    output logic                commit_reg_write
);
    import isa_pkg::*;
    import rob_pkg::*;

    // Dispatch
    logic     alu_start;
    logic     md_start;
    alu_op_t  ex_op;
    word_t    ex_a;
    word_t    ex_b;
    rob_tag_t ex_tag;

    // Allocation
    logic     alloc_valid;
    reg_idx_t alloc_dest;
    logic     alloc_reg_write;
    logic     alloc_ready_now;
    rob_tag_t tail_tag;
    logic     rob_full;

    // Write-back
    logic     alu_done;
    rob_tag_t alu_tag;
    word_t    alu_value;
    logic     mul_done;
    rob_tag_t mul_tag;
    word_t    mul_value;
    logic     div_done;
    rob_tag_t div_tag;
    word_t    div_value;
    logic     div_busy;

    inst_decode u_decode (
        .clk, .rst, .inst, .inst_valid, .op_a, .op_b, .tail_tag, .rob_full, .div_busy,
        .flush, .issue_ready, .alu_start, .md_start, .ex_op, .ex_a, .ex_b, .ex_tag,
        .alloc_valid, .alloc_dest, .alloc_reg_write, .alloc_ready_now
    );

    alu_unit u_alu (
        .clk, .rst, .flush, .start(alu_start), .op(ex_op), .a(ex_a), .b(ex_b), .tag(ex_tag),
        .done(alu_done), .result_tag(alu_tag), .result(alu_value)
    );

    muldiv_unit u_muldiv (
        .clk, .rst, .flush, .start(md_start), .op(ex_op), .a(ex_a), .b(ex_b), .tag(ex_tag),
        .mul_done, .mul_tag, .mul_value, .div_done, .div_tag, .div_value, .div_busy
    );

    reorder_buffer u_rob (
        .clk, .rst, .flush, .alloc_valid, .alloc_dest, .alloc_reg_write, .alloc_ready_now,
        .alu_done, .alu_tag, .alu_value, .mul_done, .mul_tag, .mul_value,
        .div_done, .div_tag, .div_value, .tail_tag, .rob_full,
        .commit_valid, .commit_value, .commit_dest, .commit_reg_write
    );

endmodule

`default_nettype wire

// File: rtl/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_cfg.svh"

module reorder_buffer (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              flush,            // Drops every entry
    input  wire logic              alloc_valid,
    input  wire isa_pkg::reg_idx_t alloc_dest,
    input  wire logic              alloc_reg_write,
    input  wire logic              alloc_ready_now,
    input  wire logic              alu_done,
    input  wire rob_pkg::rob_tag_t alu_tag,
    input  wire isa_pkg::word_t    alu_value,
    input  wire logic              mul_done,
    input  wire rob_pkg::rob_tag_t mul_tag,
    input  wire isa_pkg::word_t    mul_value,
    input  wire logic              div_done,
    input  wire rob_pkg::rob_tag_t div_tag,
    input  wire isa_pkg::word_t    div_value,
    output rob_pkg::rob_tag_t      tail_tag,
    output logic                   rob_full,
    output logic                   commit_valid,     // One-cycle retire pulse
    output isa_pkg::word_t         commit_value,
    output isa_pkg::reg_idx_t      commit_dest,
    output logic                   commit_reg_write
);
    import isa_pkg::*;
    import rob_pkg::*;

    logic [`ROB_DEPTH-1:0] valid_q;                  // Slot in flight
    logic [`ROB_DEPTH-1:0] ready_q;                  // Result present
    logic [`ROB_DEPTH-1:0] rw_q;
    reg_idx_t              dest_q  [`ROB_DEPTH];
    word_t                 value_q [`ROB_DEPTH];

    rob_tag_t            head;
    rob_tag_t            tail;
    logic [`ROB_TAG_W:0] count;                      // 0 .. ROB_DEPTH

    logic  hit_alu;
    logic  hit_mul;
    logic  hit_div;
    logic  head_ready;
    word_t head_value;

    // Write-back to the head this cycle retires it at the same edge
    assign hit_alu    = alu_done && (alu_tag == head);
    assign hit_mul    = mul_done && (mul_tag == head);
    assign hit_div    = div_done && (div_tag == head);
    assign head_ready = valid_q[head] && (ready_q[head] || hit_alu || hit_mul || hit_div);

    always_comb begin
        if (hit_alu) begin
            head_value = alu_value;
        end else if (hit_mul) begin
            head_value = mul_value;
        end else if (hit_div) begin
            head_value = div_value;
        end else begin
            head_value = value_q[head];
        end
    end

    // Control state
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q      <= '0;
            ready_q      <= '0;
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (alloc_valid) begin
                valid_q[tail] <= 1'b1;
                ready_q[tail] <= alloc_ready_now;
                tail          <= tail + 1'b1;        // Wraps at depth
            end
            if (alu_done && valid_q[alu_tag]) ready_q[alu_tag] <= 1'b1;
            if (mul_done && valid_q[mul_tag]) ready_q[mul_tag] <= 1'b1;
            if (div_done && valid_q[div_tag]) ready_q[div_tag] <= 1'b1;
            commit_valid <= head_ready;
            if (head_ready) begin                    // Last, so clear wins over write-back
                valid_q[head] <= 1'b0;
                ready_q[head] <= 1'b0;
                head          <= head + 1'b1;
            end
            case ({alloc_valid, head_ready})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry payload and retire data
    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            dest_q[tail]  <= alloc_dest;
            rw_q[tail]    <= alloc_reg_write;
            value_q[tail] <= '0;                     // Illegal ops retire zero
        end
        if (alu_done && valid_q[alu_tag]) value_q[alu_tag] <= alu_value;
        if (mul_done && valid_q[mul_tag]) value_q[mul_tag] <= mul_value;
        if (div_done && valid_q[div_tag]) value_q[div_tag] <= div_value;
        if (head_ready) begin
            commit_value     <= head_value;
            commit_dest      <= dest_q[head];
            commit_reg_write <= rw_q[head];
        end
    end

    assign tail_tag = tail;
    assign rob_full = count[`ROB_TAG_W];             // Depth is a power of two

endmodule

`default_nettype wire

// File: rtl/muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_cfg.svh"

module muldiv_unit (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              flush,
    input  wire logic              start,
    input  wire isa_pkg::alu_op_t  op,          // OP_MUL or OP_DIVU
    input  wire isa_pkg::word_t    a,
    input  wire isa_pkg::word_t    b,
    input  wire rob_pkg::rob_tag_t tag,
    output logic                   mul_done,
    output rob_pkg::rob_tag_t      mul_tag,
    output isa_pkg::word_t         mul_value,
    output logic                   div_done,
    output rob_pkg::rob_tag_t      div_tag,
    output isa_pkg::word_t         div_value,
    output logic                   div_busy     // Holds off issue until quotient written
);
    import isa_pkg::*;
    import rob_pkg::*;

    localparam int CNT_W = $clog2(`DIV_CYCLES);

    logic     [`MUL_STAGES-1:0] mul_vld;        // Shift of valid bits
    rob_tag_t                   mul_tg [`MUL_STAGES];
    word_t                      mul_prod [`MUL_STAGES];

    div_state_t       div_state;
    logic [CNT_W-1:0] div_cnt;
    word_t            div_q;                    // Dividend shifting out, quotient in
    word_t            div_r;                    // Partial remainder
    word_t            div_d;                    // Divisor
    rob_tag_t         div_tg;
    logic [`XLEN:0]   rem_sh;                   // Remainder with next dividend bit
    logic             fits;

    // Multiplier valid chain
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            mul_vld <= '0;
        end else begin
            mul_vld <= {mul_vld[`MUL_STAGES-2:0], start && (op == OP_MUL)};
        end
    end

    // Product computed in stage 0 then carried along with its tag
    always_ff @(posedge clk) begin
        mul_prod[0] <= a * b;                   // Low XLEN bits only
        mul_tg[0]   <= tag;
        for (int i = 1; i < `MUL_STAGES; i++) begin
            mul_prod[i] <= mul_prod[i-1];
            mul_tg[i]   <= mul_tg[i-1];
        end
    end

    assign mul_done  = mul_vld[`MUL_STAGES-1];
    assign mul_tag   = mul_tg[`MUL_STAGES-1];
    assign mul_value = mul_prod[`MUL_STAGES-1];

    // One restoring step, zero divisor always fits so quotient is all ones
    assign rem_sh = {div_r, div_q[`XLEN-1]};
    assign fits   = (rem_sh >= {1'b0, div_d});

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            div_state <= DIV_IDLE;
            div_done  <= 1'b0;
        end else begin
            div_done <= 1'b0;
            case (div_state)
                DIV_IDLE: begin
                    if (start && (op == OP_DIVU)) begin
                        div_state <= DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    if (div_cnt == CNT_W'(`DIV_CYCLES - 1)) begin
                        div_state <= DIV_DONE;
                    end
                end
                default: begin                  // DIV_DONE, pulse result
                    div_done  <= 1'b1;
                    div_state <= DIV_IDLE;
                end
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (div_state == DIV_IDLE) begin
            div_q   <= a;
            div_d   <= b;
            div_r   <= '0;
            div_cnt <= '0;
            div_tg  <= tag;
        end else if (div_state == DIV_RUN) begin
            div_r   <= fits ? word_t'(rem_sh - {1'b0, div_d}) : rem_sh[`XLEN-1:0];
            div_q   <= {div_q[`XLEN-2:0], fits};
            div_cnt <= div_cnt + 1'b1;
        end else begin
            div_value <= div_q;
        end
    end

    assign div_tag  = div_tg;
    assign div_busy = (div_state != DIV_IDLE) || div_done;

endmodule

`default_nettype wire

// File: rtl/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              flush,
    input  wire logic              start,       // Dispatch strobe from decode
    input  wire isa_pkg::alu_op_t  op,
    input  wire isa_pkg::word_t    a,
    input  wire isa_pkg::word_t    b,
    input  wire rob_pkg::rob_tag_t tag,
    output logic                   done,        // One-cycle write-back pulse
    output rob_pkg::rob_tag_t      result_tag,
    output isa_pkg::word_t         result
);
    import isa_pkg::*;
    import rob_pkg::*;

    word_t alu_out;

    always_comb begin
        case (op)
            OP_ADD:  alu_out = a + b;
            OP_SUB:  alu_out = a - b;
            OP_AND:  alu_out = a & b;
            OP_OR:   alu_out = a | b;
            OP_XOR:  alu_out = a ^ b;
            OP_SLL:  alu_out = a << b[4:0];  // Shamt is rs2[4:0]
            default: alu_out = '0;           // M ops never dispatched here
        endcase
    end

    // Done pulse, dropped by flush
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    // Payload, only loaded on start
    always_ff @(posedge clk) begin
        if (start) begin
            result     <= alu_out;
            result_tag <= tag;
        end
    end

endmodule

`default_nettype wire

// File: rtl/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire isa_pkg::word_t    inst,            // Raw 32-bit instruction
    input  wire logic              inst_valid,      // Issue strobe
    input  wire isa_pkg::word_t    op_a,            // rs1 value read upstream
    input  wire isa_pkg::word_t    op_b,            // rs2 value read upstream
    input  wire rob_pkg::rob_tag_t tail_tag,        // Next free ROB slot
    input  wire logic              rob_full,
    input  wire logic              div_busy,
    input  wire logic              flush,
    output logic                   issue_ready,
    output logic                   alu_start,
    output logic                   md_start,
    output isa_pkg::alu_op_t       ex_op,
    output isa_pkg::word_t         ex_a,
    output isa_pkg::word_t         ex_b,
    output rob_pkg::rob_tag_t      ex_tag,
    output logic                   alloc_valid,
    output isa_pkg::reg_idx_t      alloc_dest,
    output logic                   alloc_reg_write,
    output logic                   alloc_ready_now  // Illegal op with nothing to wait for
);
    import isa_pkg::*;
    import rob_pkg::*;

    localparam logic [6:0] OPC_RTYPE = 7'b0110011;
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;  // SUB
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    alu_op_t    op;
    exec_unit_t unit;
    logic       accept;

    always_comb begin
        op = OP_ILLEGAL;
        if (inst[6:0] == OPC_RTYPE) begin
            unique case ({inst[31:25], inst[14:12]})
                {F7_BASE, 3'b000}:   op = OP_ADD;
                {F7_ALT, 3'b000}:    op = OP_SUB;
                {F7_BASE, 3'b111}:   op = OP_AND;
                {F7_BASE, 3'b110}:   op = OP_OR;
                {F7_BASE, 3'b100}:   op = OP_XOR;
                {F7_BASE, 3'b001}:   op = OP_SLL;
                {F7_MULDIV, 3'b000}: op = OP_MUL;
                {F7_MULDIV, 3'b101}: op = OP_DIVU;
                default:             op = OP_ILLEGAL;
            endcase
        end
    end

    always_comb begin
        case (op)
            OP_MUL, OP_DIVU: unit = UNIT_MULDIV;
            OP_ILLEGAL:      unit = UNIT_NONE;
            default:         unit = UNIT_ALU;
        endcase
    end

    assign issue_ready = !rob_full && !div_busy;
    assign accept      = inst_valid && issue_ready && !flush;  // Drop strobe on flush

    assign alu_start = accept && (unit == UNIT_ALU);
    assign md_start  = accept && (unit == UNIT_MULDIV);
    assign ex_op     = op;
    assign ex_a      = op_a;
    assign ex_b      = op_b;
    assign ex_tag    = tail_tag;                    // Tag is the slot being allocated

    assign alloc_valid     = accept;
    assign alloc_dest      = inst[11:7];
    assign alloc_reg_write = (op != OP_ILLEGAL) && (inst[11:7] != 5'd0);  // x0 never written
    assign alloc_ready_now = (unit == UNIT_NONE);

endmodule

`default_nettype wire

// File: rtl/rob_pkg.sv
`default_nettype none

`include "rob_cfg.svh"

package rob_pkg;

    // Reorder buffer index
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // Execute unit selected at dispatch
    typedef enum logic [1:0] {
        UNIT_ALU    = 2'd0,
        UNIT_MULDIV = 2'd1,
        UNIT_NONE   = 2'd2  // No unit, entry is ready at allocation
    } exec_unit_t;

    // Iterative divider control
    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } div_state_t;

endpackage

`default_nettype wire

// File: rtl/isa_pkg.sv
`default_nettype none

`include "rob_cfg.svh"

package isa_pkg;

    // Operand or result word
    typedef logic [`XLEN-1:0] word_t;

    // Architectural register number
    typedef logic [4:0] reg_idx_t;

    // Decoded R-type operation
    typedef enum logic [3:0] {
        OP_ADD     = 4'd0,
        OP_SUB     = 4'd1,
        OP_AND     = 4'd2,
        OP_OR      = 4'd3,
        OP_XOR     = 4'd4,
        OP_SLL     = 4'd5,
        OP_MUL     = 4'd6,  // M extension, low half
        OP_DIVU    = 4'd7,  // M extension, unsigned quotient
        OP_ILLEGAL = 4'd15  // Unknown encoding, retires as a no-op
    } alu_op_t;

endpackage

`default_nettype wire

// File: rtl/rob_cfg.svh
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// Datapath width
`define XLEN 32

// Reorder buffer sizing, depth must be 2**ROB_TAG_W
`define ROB_DEPTH 16
`define ROB_TAG_W 4

// Execute latencies
`define MUL_STAGES 3
`define DIV_CYCLES 32

`endif
